// File: design/mem_pkg.sv
package mem_pkg;

    // One request from the core, sampled every cycle
    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [2:0]  funct3;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    // Read word seen as byte lanes or as half lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } word_view_u;

    // Load codes
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;

    // Store codes
    localparam logic [2:0] f3_sb = 3'b000;
    localparam logic [2:0] f3_sh = 3'b001;
    localparam logic [2:0] f3_sw = 3'b010;

    // Region select bits, RAM wins over I/O
    localparam int ram_sel_bit = 31;
    localparam int io_sel_bit  = 20;

    // Region codes held in the load context
    localparam logic [1:0] region_none = 2'd0;
    localparam logic [1:0] region_ram  = 2'd1;
    localparam logic [1:0] region_io   = 2'd2;

    // I/O word map
    localparam int io_rom_words   = 3;  // ID words at 0 to 2
    localparam int io_word_switch = 4;
    localparam int io_word_led    = 5;

    localparam logic [31:0] rom_id_0 = 32'h5256_3332;  // "RV32"
    localparam logic [31:0] rom_id_1 = 32'h444d_454d;  // "DMEM"
    localparam logic [31:0] rom_id_2 = 32'h0001_0002;  // Revision

endpackage

// File: design/store_align.sv
`timescale 1ns/1ns

module store_align (
    input  logic [2:0]  funct3,
    input  logic [1:0]  offset,
    input  logic [31:0] wdata,
    output logic [3:0]  be,
    output logic [31:0] wdata_aligned
);
    import mem_pkg::*;

    // Data is replicated so every lane holds the value
    // and the byte enables pick the lanes that are written
    always_comb begin
        be            = 4'b0000;
        wdata_aligned = wdata;
        case (funct3)
            f3_sb: begin
                be            = 4'b0001 << offset;
                wdata_aligned = {4{wdata[7:0]}};
            end
            f3_sh: begin
                be            = offset[1] ? 4'b1100 : 4'b0011;
                wdata_aligned = {2{wdata[15:0]}};
            end
            f3_sw: begin
                be = 4'b1111;  // Offset must be zero
            end
            default: begin
                be = 4'b0000;  // Not a store size
            end
        endcase
    end

endmodule

// File: design/data_ram.sv
`timescale 1ns/1ns

module data_ram #(
    parameter int ram_words = 256
) (
    input  logic                         clk,
    input  logic                         rd,
    input  logic [3:0]                   be,
    input  logic [$clog2(ram_words)-1:0] index,
    input  logic [31:0]                  wdata,
    output logic [31:0]                  rdata
);

    logic [31:0] mem [ram_words];

    // Registered read, old contents on a same-word write
    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= mem[index];
        end
    end

    // Per-byte writes
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                mem[index][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

endmodule

// File: design/io_rom_block.sv
`timescale 1ns/1ns

module io_rom_block (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rd,
    input  logic [3:0]  be,
    input  logic [2:0]  index,
    input  logic [31:0] wdata,
    input  logic [15:0] switch,
    output logic [31:0] rdata,
    output logic [15:0] led
);
    import mem_pkg::*;

    localparam logic [31:0] rom_words [io_rom_words] = '{rom_id_0, rom_id_1, rom_id_2};

    logic [31:0] read_word;
    logic        led_hit;

    assign led_hit = (index == 3'(io_word_led));

    always_comb begin
        read_word = 32'h0000_0000;
        if (index < 3'(io_rom_words)) begin
            read_word = rom_words[index[1:0]];
        end else if (index == 3'(io_word_switch)) begin
            read_word = {16'h0000, switch};
        end else if (led_hit) begin
            read_word = {16'h0000, led};
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= read_word;
        end
    end

    // Only the two low lanes exist
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led <= 16'h0000;
        end else if (led_hit) begin
            if (be[0]) begin
                led[7:0] <= wdata[7:0];
            end
            if (be[1]) begin
                led[15:8] <= wdata[15:8];
            end
        end
    end

endmodule

// File: design/load_extend.sv
`timescale 1ns/1ns

module load_extend (
    input  logic [2:0]          funct3,
    input  logic [1:0]          offset,
    input  mem_pkg::word_view_u raw,
    output logic [31:0]         data
);
    import mem_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign sel_byte = raw.bytes[offset];
    assign sel_half = raw.halves[offset[1]];

    always_comb begin
        case (funct3)
            f3_lb: begin
                data = {{24{sel_byte[7]}}, sel_byte};
            end
            f3_lh: begin
                data = {{16{sel_half[15]}}, sel_half};
            end
            f3_lw: begin
                data = raw.bytes;  // Whole word
            end
            f3_lbu: begin
                data = {24'h000000, sel_byte};
            end
            f3_lhu: begin
                data = {16'h0000, sel_half};
            end
            default: begin
                data = 32'h0000_0000;
            end
        endcase
    end

endmodule

// File: design/data_mem.sv
`timescale 1ns/1ns

module data_mem #(
    parameter int ram_words = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::mem_req_t req,
    input  logic [15:0]       switch,
    output logic [31:0]       rdata,
    output logic [15:0]       led
);
    import mem_pkg::*;

    localparam int ram_aw = $clog2(ram_words);

    logic [1:0]  region;
    logic [3:0]  be;
    logic [31:0] wdata_aligned;
    logic [3:0]  ram_be;
    logic [3:0]  io_be;
    logic        ram_rd;
    logic        io_rd;
    logic [31:0] ram_rdata;
    logic [31:0] io_rdata;
    logic [1:0]  ctx_region;
    logic [2:0]  ctx_funct3;
    logic [1:0]  ctx_offset;
    word_view_u  raw_word;

    always_comb begin
        if (req.addr[ram_sel_bit]) begin
            region = region_ram;
        end else if (req.addr[io_sel_bit]) begin
            region = region_io;
        end else begin
            region = region_none;  // Reads zero, writes dropped
        end
    end

    store_align u_store_align (
        .funct3        (req.funct3),
        .offset        (req.addr[1:0]),
        .wdata         (req.wdata),
        .be            (be),
        .wdata_aligned (wdata_aligned)
    );

    assign ram_be = (req.wr && region == region_ram) ? be : 4'b0000;
    assign io_be  = (req.wr && region == region_io) ? be : 4'b0000;
    assign ram_rd = req.rd && region == region_ram;
    assign io_rd  = req.rd && region == region_io;

    data_ram #(
        .ram_words (ram_words)
    ) u_data_ram (
        .clk   (clk),
        .rd    (ram_rd),
        .be    (ram_be),
        .index (req.addr[ram_aw+1:2]),
        .wdata (wdata_aligned),
        .rdata (ram_rdata)
    );

    io_rom_block u_io_rom_block (
        .clk    (clk),
        .rst_n  (rst_n),
        .rd     (io_rd),
        .be     (io_be),
        .index  (req.addr[4:2]),
        .wdata  (wdata_aligned),
        .switch (switch),
        .rdata  (io_rdata),
        .led    (led)
    );

    // Context of the load whose word is now in the block registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctx_region <= region_none;
            ctx_funct3 <= f3_lw;
            ctx_offset <= 2'b00;
        end else if (req.rd) begin
            ctx_region <= region;
            ctx_funct3 <= req.funct3;
            ctx_offset <= req.addr[1:0];
        end
    end

    always_comb begin
        case (ctx_region)
            region_ram: raw_word = ram_rdata;
            region_io:  raw_word = io_rdata;
            default:    raw_word = 32'h0000_0000;
        endcase
    end

    load_extend u_load_extend (
        .funct3 (ctx_funct3),
        .offset (ctx_offset),
        .raw    (raw_word),
        .data   (rdata)
    );

    assert property (@(posedge clk) disable iff (!rst_n) !(req.rd && req.wr))
        else $error("rd and wr high together");

    // Store sizes come from store_align, load sizes from load_extend
    assert property (@(posedge clk) disable iff (!rst_n)
        (req.rd && (req.funct3 == f3_lh || req.funct3 == f3_lhu)) ||
        (req.wr && req.funct3 == f3_sh) |-> !req.addr[0])
        else $error("Misaligned half access");

    assert property (@(posedge clk) disable iff (!rst_n)
        (req.rd && req.funct3 == f3_lw) || (req.wr && req.funct3 == f3_sw)
        |-> req.addr[1:0] == 2'b00)
        else $error("Misaligned word access");

endmodule

// File: bench/data_mem_tb.sv
`timescale 1ns/1ns

module data_mem_tb;
    import mem_pkg::*;

    localparam int ram_words  = 256;
    localparam int ram_aw     = $clog2(ram_words);
    localparam int n_store    = 400;
    localparam int n_load     = 400;
    localparam int n_io       = 60;
    localparam int n_led      = 60;
    localparam int n_unmapped = 60;
    localparam int n_alt      = 120;
    // Led and unmapped loops take two cycles each
    localparam int total_cycles = 4 + ram_words + n_store + n_load + n_io
                                  + 2 * n_led + 2 * n_unmapped + n_alt + 1;

    logic        clk;
    logic        rst_n;
    mem_req_t    req;
    logic [15:0] switch;
    logic [31:0] rdata;
    logic [15:0] led;

    integer      seed;
    logic [7:0]  model_ram [ram_words*4];
    logic [15:0] led_model;
    logic        pending;      // A read result is due this cycle
    logic [31:0] pending_exp;

    data_mem #(
        .ram_words (ram_words)
    ) u_data_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .switch (switch),
        .rdata  (rdata),
        .led    (led)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s = %08h, expected %08h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "Stopped on the first mismatch");
        end
    endtask

    function automatic logic [2:0] pick_load();
        logic [31:0] r;
        r = next_rand();
        case (r % 5)
            0: return f3_lb;
            1: return f3_lh;
            2: return f3_lw;
            3: return f3_lbu;
            default: return f3_lhu;
        endcase
    endfunction

    function automatic logic [2:0] pick_store();
        logic [31:0] r;
        r = next_rand();
        case (r % 3)
            0: return f3_sb;
            1: return f3_sh;
            default: return f3_sw;
        endcase
    endfunction

    // Low funct3 bits give the access size for loads and stores alike
    function automatic logic [1:0] rand_offset(logic [2:0] f3);
        logic [31:0] r;
        r = next_rand();
        case (f3[1:0])
            2'b00: return r[1:0];
            2'b01: return {r[1], 1'b0};
            default: return 2'b00;
        endcase
    endfunction

    function automatic logic [ram_aw-1:0] rand_ram_index();
        logic [31:0] r;
        r = next_rand();
        return r[ram_aw-1:0];
    endfunction

    // Upper bits stay random, bit 31 must win over bit 20
    function automatic logic [31:0] ram_addr(logic [ram_aw-1:0] index, logic [2:0] f3);
        logic [31:0] a;
        a = next_rand();
        a[ram_sel_bit] = 1'b1;
        a[ram_aw+1:2] = index;
        a[1:0] = rand_offset(f3);
        return a;
    endfunction

    function automatic logic [31:0] io_addr(logic [2:0] index, logic [2:0] f3);
        logic [31:0] a;
        a = next_rand();
        a[ram_sel_bit] = 1'b0;
        a[io_sel_bit] = 1'b1;
        a[4:2] = index;
        a[1:0] = rand_offset(f3);
        return a;
    endfunction

    // Unmapped space or an unused I/O word
    function automatic logic [31:0] dead_addr(logic [2:0] f3);
        logic [31:0] a;
        logic [31:0] r;
        r = next_rand();
        case (r[1:0])
            2'b00: begin
                a = next_rand();
                a[ram_sel_bit] = 1'b0;
                a[io_sel_bit] = 1'b0;
                a[1:0] = rand_offset(f3);
            end
            2'b01: a = io_addr(3'd3, f3);
            2'b10: a = io_addr(3'd6, f3);
            default: a = io_addr(3'd7, f3);
        endcase
        return a;
    endfunction

    function automatic mem_req_t load_req(logic [2:0] f3, logic [31:0] addr);
        mem_req_t r;
        r = '0;
        r.rd = 1'b1;
        r.funct3 = f3;
        r.addr = addr;
        return r;
    endfunction

    function automatic mem_req_t store_req(logic [2:0] f3, logic [31:0] addr,
                                           logic [31:0] wdata);
        mem_req_t r;
        r = '0;
        r.wr = 1'b1;
        r.funct3 = f3;
        r.addr = addr;
        r.wdata = wdata;
        return r;
    endfunction

    function automatic logic [31:0] ram_word(logic [ram_aw-1:0] index);
        int base;
        base = int'(index) * 4;
        return {model_ram[base+3], model_ram[base+2], model_ram[base+1], model_ram[base]};
    endfunction

    // Expected rdata of a load, taken when the load is issued
    function automatic logic [31:0] expected_load(mem_req_t r);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        word = 32'h0000_0000;
        if (r.addr[ram_sel_bit]) begin
            word = ram_word(r.addr[ram_aw+1:2]);
        end else if (r.addr[io_sel_bit]) begin
            case (int'(r.addr[4:2]))
                0: word = rom_id_0;
                1: word = rom_id_1;
                2: word = rom_id_2;
                io_word_switch: word = {16'h0000, switch};
                io_word_led: word = {16'h0000, led_model};
                default: word = 32'h0000_0000;
            endcase
        end
        b = word[8*r.addr[1:0] +: 8];
        h = word[16*r.addr[1] +: 16];
        case (r.funct3)
            f3_lb: return {{24{b[7]}}, b};
            f3_lh: return {{16{h[15]}}, h};
            f3_lw: return word;
            f3_lbu: return {24'h000000, b};
            f3_lhu: return {16'h0000, h};
            default: return 32'h0000_0000;
        endcase
    endfunction

    // Byte k of the store data lands at address offset + k
    task automatic model_store(input mem_req_t r);
        int n;
        int lane;
        n = (r.funct3[1:0] == 2'b00) ? 1 : (r.funct3[1:0] == 2'b01) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            lane = int'(r.addr[1:0]) + k;
            if (r.addr[ram_sel_bit]) begin
                model_ram[int'(r.addr[ram_aw+1:2]) * 4 + lane] = r.wdata[8*k +: 8];
            end else if (r.addr[io_sel_bit] && int'(r.addr[4:2]) == io_word_led && lane < 2) begin
                led_model[8*lane +: 8] = r.wdata[8*k +: 8];
            end
        end
    endtask

    // One clock: check what the last edge produced, then drive the next request
    task automatic step(input mem_req_t r);
        logic [31:0] sw;
        @(posedge clk);
        #1;
        if (pending) begin
            check_value("rdata", rdata, pending_exp);
        end
        check_value("led", {16'h0000, led}, {16'h0000, led_model});
        sw = next_rand();
        switch = sw[15:0];
        req = r;
        pending = r.rd;
        if (r.rd) begin
            pending_exp = expected_load(r);
        end
        if (r.wr) begin
            model_store(r);
        end
    endtask

    initial begin
        logic [2:0]  f3;
        logic [2:0]  idx;
        logic [31:0] r;
        seed = 32'h56e4fe5a;
        clk = 1'b0;
        rst_n = 1'b0;
        req = '0;
        switch = 16'h0000;
        pending = 1'b0;
        pending_exp = 32'h0000_0000;
        led_model = 16'h0000;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("rdata", rdata, 32'h0000_0000);
        check_value("led", {16'h0000, led}, 32'h0000_0000);

        for (int i = 0; i < ram_words; i++) begin  // Every RAM word gets known contents
            step(store_req(f3_sw, ram_addr(i[ram_aw-1:0], f3_sw),
                           (i * 32'h9e37_79b1) ^ 32'h5a5a_0f0f));
        end
        for (int i = 0; i < n_store; i++) begin
            f3 = pick_store();
            step(store_req(f3, ram_addr(rand_ram_index(), f3), next_rand()));
        end
        for (int i = 0; i < n_load; i++) begin
            f3 = pick_load();
            step(load_req(f3, ram_addr(rand_ram_index(), f3)));
        end

        // ID words and switches
        for (int i = 0; i < n_io; i++) begin
            r = next_rand();
            idx = (r[1:0] == 2'b11) ? 3'(io_word_switch) : {1'b0, r[1:0]};
            f3 = pick_load();
            step(load_req(f3, io_addr(idx, f3)));
        end
        for (int i = 0; i < n_led; i++) begin
            f3 = pick_store();
            step(store_req(f3, io_addr(3'(io_word_led), f3), next_rand()));
            f3 = pick_load();
            step(load_req(f3, io_addr(3'(io_word_led), f3)));
        end
        for (int i = 0; i < n_unmapped; i++) begin
            f3 = pick_store();
            step(store_req(f3, dead_addr(f3), next_rand()));
            f3 = pick_load();
            step(load_req(f3, dead_addr(f3)));
        end

        // Back-to-back reads rotating through the regions
        for (int i = 0; i < n_alt; i++) begin
            f3 = pick_load();
            r = next_rand();
            case (i % 3)
                0: step(load_req(f3, ram_addr(rand_ram_index(), f3)));
                1: step(load_req(f3, io_addr(r[2:0], f3)));
                default: step(load_req(f3, dead_addr(f3)));
            endcase
        end
        step('0);

        $display("TEST OK");
        $finish;
    end

    initial begin
        #((total_cycles + 100) * 20);
        $display("Watchdog expired before the test sequence finished");
        $display("TEST FAILED");
        $fatal(1, "Timeout");
    end

endmodule

// File: verilog.f
design/mem_pkg.sv
design/store_align.sv
design/data_ram.sv
design/io_rom_block.sv
design/load_extend.sv
design/data_mem.sv
bench/data_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the data memory testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module data_mem_tb \
    -Mdir "$build_dir"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/Vdata_mem_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "TEST FAILED" "$log_file"; then
    echo "Simulation reported a failure, see $log_file"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "Simulation passed"
exit 0
